// File: bench/decoderChecks.svh
// --------------------
// Failure exit
// --------------------

task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
endtask

// --------------------
// Typed compares
// --------------------

// One strobe bit against the model
task automatic checkBit(input string testName, input string sigName,
                        input logic expected, input logic actual);
    if (actual !== expected) begin
        stopOnFailure($sformatf("ERROR %s: %s expected %b actual %b",
                                testName, sigName, expected, actual));
    end
endtask

// Registered ALU select against the model
task automatic checkAluOp(input string testName, input decPkg::aluOpT expected,
                          input decPkg::aluOpT actual);
    if (actual !== expected) begin
        stopOnFailure($sformatf("ERROR %s: aluOp expected %s (%0d) actual %s (%0d)",
                                testName, expected.name(), expected,
                                actual.name(), actual));
    end
endtask

// File: bench/decoderTb.sv
module decoderTb;

    localparam int halfPeriod   = 20;                 // 40 unit clock period
    localparam int settleDelay  = 5;                  // Strobe sample point after a drive
    localparam int resetTimeout = 10;                 // Cycles allowed for reset release
    // Bit positions in a strobe table entry
    localparam int pushBit      = 7;
    localparam int popBit       = 6;
    localparam int memWrBit     = 5;
    localparam int indLoadBit   = 4;
    localparam int indStoreBit  = 3;
    localparam int bitRevBit    = 2;
    localparam int reqInBit     = 1;
    localparam int outEnBit     = 0;

    logic           clk;
    logic           arstN;
    decPkg::opcodeT opcode;
    decPkg::aluOpT  aluOp;
    logic           push;
    logic           pop;
    logic           memWr;
    logic           indLoad;
    logic           indStore;
    logic           bitRev;
    logic           reqIn;
    logic           outEn;

    logic [7:0]     strobeTab [0:127];               // Expected strobes per code
    decPkg::aluOpT  aluTab    [0:127];               // Expected ALU select per code
    decPkg::aluOpT  expectedAlu;                      // Model of the ALU code register
    int             seed;

    `include "decoderChecks.svh"

    decoderTop #(
        .enableStack (1'b1),
        .enableIo    (1'b1)
    ) u_decoderTop (
        .clk      (clk),
        .arstN    (arstN),
        .opcode   (opcode),
        .aluOp    (aluOp),
        .push     (push),
        .pop      (pop),
        .memWr    (memWr),
        .indLoad  (indLoad),
        .indStore (indStore),
        .bitRev   (bitRev),
        .reqIn    (reqIn),
        .outEn    (outEn)
    );

    // --------------------
    // Clock and reset
    // --------------------

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk;

    initial begin
        arstN = 1'b0;                                 // Low for two cycles
        repeat (2) @(negedge clk);
        arstN = 1'b1;
    end

    // --------------------
    // Reference tables
    // --------------------

    // S_ form always sits one code above its memory form
    task automatic setAluPair(input logic [6:0] memCode, input decPkg::aluOpT op,
                              input bit hasStackForm);
        aluTab[memCode] = op;
        if (hasStackForm) begin
            aluTab[memCode + 7'd1]            = op;
            strobeTab[memCode + 7'd1][popBit] = 1'b1; // Second operand off the stack
        end
    endtask

    task automatic buildTables();
        for (int i = 0; i < 128; i++) begin
            strobeTab[i[6:0]] = 8'h00;                // Unused codes act as NOP
            aluTab[i[6:0]]    = decPkg::aluPass;
        end
        strobeTab[decPkg::P_LOD][pushBit]    = 1'b1;
        strobeTab[decPkg::PSH][pushBit]      = 1'b1;
        strobeTab[decPkg::P_INN][pushBit]    = 1'b1;
        strobeTab[decPkg::SET_P][popBit]     = 1'b1;
        strobeTab[decPkg::STI][popBit]       = 1'b1;
        strobeTab[decPkg::ISI][popBit]       = 1'b1;
        strobeTab[decPkg::POP][popBit]       = 1'b1;
        strobeTab[decPkg::SET][memWrBit]     = 1'b1;
        strobeTab[decPkg::SET_P][memWrBit]   = 1'b1;
        strobeTab[decPkg::STI][memWrBit]     = 1'b1;
        strobeTab[decPkg::ISI][memWrBit]     = 1'b1;
        strobeTab[decPkg::LDI][indLoadBit]   = 1'b1;
        strobeTab[decPkg::ILI][indLoadBit]   = 1'b1;
        strobeTab[decPkg::STI][indStoreBit]  = 1'b1;
        strobeTab[decPkg::ISI][indStoreBit]  = 1'b1;
        strobeTab[decPkg::ILI][bitRevBit]    = 1'b1;
        strobeTab[decPkg::ISI][bitRevBit]    = 1'b1;
        strobeTab[decPkg::INN][reqInBit]     = 1'b1;
        strobeTab[decPkg::P_INN][reqInBit]   = 1'b1;
        strobeTab[decPkg::OUT][outEnBit]     = 1'b1;
        // Acc reloaded from memory or stack
        aluTab[decPkg::LOD]   = decPkg::aluLoad;
        aluTab[decPkg::P_LOD] = decPkg::aluLoad;
        aluTab[decPkg::LDI]   = decPkg::aluLoad;
        aluTab[decPkg::ILI]   = decPkg::aluLoad;
        aluTab[decPkg::SET_P] = decPkg::aluLoad;
        aluTab[decPkg::POP]   = decPkg::aluLoad;
        setAluPair(decPkg::ADD, decPkg::aluAdd, 1'b1);
        setAluPair(decPkg::MLT, decPkg::aluMul, 1'b1);
        setAluPair(decPkg::DIV, decPkg::aluDiv, 1'b1);
        setAluPair(decPkg::MOD, decPkg::aluMod, 1'b1);
        setAluPair(decPkg::NEG, decPkg::aluNeg, 1'b0);
        setAluPair(decPkg::ABS, decPkg::aluAbs, 1'b0);
        setAluPair(decPkg::AND, decPkg::aluAnd, 1'b1);
        setAluPair(decPkg::ORR, decPkg::aluOr, 1'b1);
        setAluPair(decPkg::XOR, decPkg::aluXor, 1'b1);
        setAluPair(decPkg::INV, decPkg::aluInv, 1'b0);
        setAluPair(decPkg::LES, decPkg::aluLess, 1'b1);
        setAluPair(decPkg::GRE, decPkg::aluGreater, 1'b1);
        setAluPair(decPkg::EQU, decPkg::aluEqual, 1'b1);
        setAluPair(decPkg::SHL, decPkg::aluShl, 1'b1);
        setAluPair(decPkg::SHR, decPkg::aluShr, 1'b1);
        setAluPair(decPkg::SRS, decPkg::aluSra, 1'b1);
    endtask

    // --------------------
    // Drive and compare
    // --------------------

    task automatic checkStrobes(input string testName, input logic [7:0] expected);
        checkBit(testName, "push", expected[pushBit], push);
        checkBit(testName, "pop", expected[popBit], pop);
        checkBit(testName, "memWr", expected[memWrBit], memWr);
        checkBit(testName, "indLoad", expected[indLoadBit], indLoad);
        checkBit(testName, "indStore", expected[indStoreBit], indStore);
        checkBit(testName, "bitRev", expected[bitRevBit], bitRev);
        checkBit(testName, "reqIn", expected[reqInBit], reqIn);
        checkBit(testName, "outEn", expected[outEnBit], outEn);
    endtask

    // Entered on a falling edge and returns on the next one
    task automatic stepOp(input string testName, input decPkg::opcodeT op);
        string label;
        label  = $sformatf("%s op %0d", testName, op);
        opcode = op;
        #settleDelay;
        checkStrobes(label, strobeTab[op]);          // Same cycle
        checkAluOp(label, expectedAlu, aluOp);       // Old code until the edge
        @(negedge clk);
        if (op != decPkg::NOP) begin
            expectedAlu = aluTab[op];                 // NOP holds the register
        end
        checkAluOp(label, expectedAlu, aluOp);
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (arstN !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > resetTimeout) begin
                stopOnFailure("Timeout: reset was never released");
            end
        end
        @(negedge clk);                               // Line up with the drive edge
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic resetTest();
        checkAluOp("resetTest", decPkg::aluPass, aluOp);
        checkStrobes("resetTest", 8'h00);
    endtask

    // LOD through RET fill codes 0 to 16
    task automatic controlOpsTest();
        for (int i = 0; i <= 16; i++) begin
            stepOp("controlOpsTest", decPkg::opcodeT'(i[6:0]));
        end
    endtask

    task automatic aluOpsTest();
        decPkg::opcodeT ops [23];
        ops = '{decPkg::ADD, decPkg::S_ADD, decPkg::MLT, decPkg::S_MLT, decPkg::DIV,
                decPkg::S_DIV, decPkg::MOD, decPkg::S_MOD, decPkg::NEG, decPkg::ABS,
                decPkg::AND, decPkg::S_AND, decPkg::ORR, decPkg::S_ORR, decPkg::XOR,
                decPkg::S_XOR, decPkg::INV, decPkg::LES, decPkg::S_LES, decPkg::GRE,
                decPkg::S_GRE, decPkg::EQU, decPkg::S_EQU};
        for (int i = 0; i < 23; i++) begin
            stepOp("aluOpsTest", ops[i]);
        end
        stepOp("aluOpsTest", decPkg::SHL);            // Shifts
        stepOp("aluOpsTest", decPkg::S_SHL);
        stepOp("aluOpsTest", decPkg::SHR);
        stepOp("aluOpsTest", decPkg::S_SHR);
        stepOp("aluOpsTest", decPkg::SRS);
        stepOp("aluOpsTest", decPkg::S_SRS);
    endtask

    task automatic nopHoldTest();
        stepOp("nopHoldTest", decPkg::ADD);
        repeat (3) begin
            stepOp("nopHoldTest", decPkg::NOP);
            checkAluOp("nopHoldTest", decPkg::aluAdd, aluOp);
        end
        stepOp("nopHoldTest", decPkg::SHL);           // Follows after one edge
    endtask

    task automatic randomSweep();
        int randVal;
        for (int i = 0; i < 200; i++) begin
            randVal = $random(seed);
            stepOp("randomSweep", decPkg::opcodeT'(7'(randVal & 32'h7f)));
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        opcode      = decPkg::NOP;                    // Idle through reset
        seed        = 32'ha422bac8;
        expectedAlu = decPkg::aluPass;
        buildTables();
        waitResetRelease();
        resetTest();
        controlOpsTest();
        aluOpsTest();
        nopHoldTest();
        randomSweep();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
+incdir+bench
hdl/decPkg.sv
hdl/instrDecode.sv
hdl/aluOpReg.sv
hdl/decoderTop.sv
bench/decoderTb.sv

// File: hdl/aluOpReg.sv
module aluOpReg (
    input  logic           clk,
    input  logic           arstN,                     // Async reset, active low
    input  decPkg::opcodeT opcode,                    // Current instruction
    output decPkg::aluOpT  aluOp                      // ALU select, one cycle late
);

    decPkg::aluOpT aluOpNext;                         // Mapped code for this opcode

    // --------------------
    // Opcode to ALU code
    // --------------------

    always_comb begin
        case (opcode)
            // Acc takes a new value from memory or stack
            decPkg::LOD,
            decPkg::P_LOD,
            decPkg::LDI,
            decPkg::ILI,
            decPkg::SET_P,                            // Stack top into acc
            decPkg::POP:   aluOpNext = decPkg::aluLoad;
            // Acc untouched
            decPkg::SET,
            decPkg::STI,
            decPkg::ISI,
            decPkg::PSH,
            decPkg::INN,                              // Input path bypasses the ALU
            decPkg::P_INN,
            decPkg::OUT,
            decPkg::JMP,
            decPkg::JIZ,
            decPkg::CAL,
            decPkg::RET:   aluOpNext = decPkg::aluPass;
            // Arithmetic
            decPkg::ADD,
            decPkg::S_ADD: aluOpNext = decPkg::aluAdd;
            decPkg::MLT,
            decPkg::S_MLT: aluOpNext = decPkg::aluMul;
            decPkg::DIV,
            decPkg::S_DIV: aluOpNext = decPkg::aluDiv;
            decPkg::MOD,
            decPkg::S_MOD: aluOpNext = decPkg::aluMod;
            decPkg::NEG:   aluOpNext = decPkg::aluNeg;
            decPkg::ABS:   aluOpNext = decPkg::aluAbs;
            // Bitwise
            decPkg::AND,
            decPkg::S_AND: aluOpNext = decPkg::aluAnd;
            decPkg::ORR,
            decPkg::S_ORR: aluOpNext = decPkg::aluOr;
            decPkg::XOR,
            decPkg::S_XOR: aluOpNext = decPkg::aluXor;
            decPkg::INV:   aluOpNext = decPkg::aluInv;
            // Compare
            decPkg::LES,
            decPkg::S_LES: aluOpNext = decPkg::aluLess;
            decPkg::GRE,
            decPkg::S_GRE: aluOpNext = decPkg::aluGreater;
            decPkg::EQU,
            decPkg::S_EQU: aluOpNext = decPkg::aluEqual;
            // Shifts
            decPkg::SHL,
            decPkg::S_SHL: aluOpNext = decPkg::aluShl;
            decPkg::SHR,
            decPkg::S_SHR: aluOpNext = decPkg::aluShr;
            decPkg::SRS,
            decPkg::S_SRS: aluOpNext = decPkg::aluSra;
            // Unknown codes leave the acc alone
            default:       aluOpNext = decPkg::aluPass;
        endcase
    end

    // --------------------
    // ALU code register
    // --------------------

    // NOP keeps the previous code so a multi-cycle op keeps its select
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluOp <= decPkg::aluPass;                 // Idle ALU out of reset
        end else if (opcode != decPkg::NOP) begin
            aluOp <= aluOpNext;
        end
    end

endmodule

// File: hdl/decPkg.sv
package decPkg;

    // --------------------
    // Widths
    // --------------------

    localparam int opcodeWidth = 7;                   // Instruction opcode field
    localparam int aluOpWidth  = 6;                   // ALU operation select

    // --------------------
    // Opcodes
    // --------------------

    // Codes missing from this list decode as NOP
    typedef enum logic [opcodeWidth-1:0] {
        // Memory access
        LOD    = 7'd0,                                // Load acc from data memory
        P_LOD  = 7'd1,                                // Push, then load
        LDI    = 7'd2,                                // Indirect load
        ILI    = 7'd3,                                // Indirect load, bit-reversed address
        SET    = 7'd4,                                // Store acc to data memory
        SET_P  = 7'd5,                                // Store, then pop
        STI    = 7'd6,                                // Indirect store
        ISI    = 7'd7,                                // Indirect store, bit-reversed address
        // Data stack
        PSH    = 7'd8,
        POP    = 7'd9,
        // I/O ports
        INN    = 7'd10,                               // Read input port
        P_INN  = 7'd11,                               // Push, then read input
        OUT    = 7'd12,                               // Write output port
        // Flow control, handled by the prefetch stage
        JMP    = 7'd13,
        JIZ    = 7'd14,
        CAL    = 7'd15,
        RET    = 7'd16,
        // Integer arithmetic
        ADD    = 7'd17,
        S_ADD  = 7'd18,
        MLT    = 7'd21,
        S_MLT  = 7'd22,
        DIV    = 7'd25,
        S_DIV  = 7'd26,
        MOD    = 7'd29,
        S_MOD  = 7'd30,
        NEG    = 7'd35,                               // Two's complement of acc
        ABS    = 7'd41,                               // Absolute value of acc
        // Bitwise
        AND    = 7'd62,
        S_AND  = 7'd63,
        ORR    = 7'd64,
        S_ORR  = 7'd65,
        XOR    = 7'd66,
        S_XOR  = 7'd67,
        INV    = 7'd68,                               // Invert acc bits
        // Compare
        LES    = 7'd78,
        S_LES  = 7'd79,
        GRE    = 7'd82,
        S_GRE  = 7'd83,
        EQU    = 7'd86,
        S_EQU  = 7'd87,
        // Shifts
        SHL    = 7'd88,
        S_SHL  = 7'd89,
        SHR    = 7'd90,
        S_SHR  = 7'd91,
        SRS    = 7'd92,                               // Arithmetic shift right
        S_SRS  = 7'd93,
        // Idle
        NOP    = 7'd94                                // Holds the ALU code
    } opcodeT;

    // --------------------
    // ALU operations
    // --------------------

    // S_ forms share the code of the memory form, only the operand source differs
    typedef enum logic [aluOpWidth-1:0] {
        aluPass    = 6'd0,                            // Acc unchanged
        aluLoad    = 6'd1,                            // Acc takes the operand
        aluAdd     = 6'd2,
        aluMul     = 6'd4,
        aluDiv     = 6'd6,
        aluMod     = 6'd8,
        aluNeg     = 6'd11,
        aluAbs     = 6'd15,
        aluAnd     = 6'd29,
        aluOr      = 6'd30,
        aluXor     = 6'd31,
        aluInv     = 6'd32,
        aluLess    = 6'd38,
        aluGreater = 6'd40,
        aluEqual   = 6'd42,
        aluShl     = 6'd43,
        aluShr     = 6'd44,
        aluSra     = 6'd45
    } aluOpT;

endpackage

// File: hdl/decoderTop.sv
module decoderTop #(
    parameter bit enableStack = 1'b1,                 // Build with data stack strobes
    parameter bit enableIo    = 1'b1                  // Build with I/O port strobes
) (
    input  logic           clk,
    input  logic           arstN,                     // Async reset, active low
    input  decPkg::opcodeT opcode,                    // Instruction from fetch
    output decPkg::aluOpT  aluOp,                     // Registered ALU select
    output logic           push,                      // Strobes below are same cycle
    output logic           pop,
    output logic           memWr,
    output logic           indLoad,
    output logic           indStore,
    output logic           bitRev,
    output logic           reqIn,
    output logic           outEn
);

    // --------------------
    // Control strobes
    // --------------------

    instrDecode #(
        .enableStack (enableStack),
        .enableIo    (enableIo)
    ) u_instrDecode (
        .opcode   (opcode),
        .push     (push),
        .pop      (pop),
        .memWr    (memWr),
        .indLoad  (indLoad),
        .indStore (indStore),
        .bitRev   (bitRev),
        .reqIn    (reqIn),
        .outEn    (outEn)
    );

    // --------------------
    // ALU select
    // --------------------

    // Registered so the ALU sees the code with its operand one cycle later
    aluOpReg u_aluOpReg (
        .clk    (clk),
        .arstN  (arstN),
        .opcode (opcode),
        .aluOp  (aluOp)
    );

endmodule

// File: hdl/instrDecode.sv
module instrDecode #(
    parameter bit enableStack = 1'b1,                 // Data stack strobes present
    parameter bit enableIo    = 1'b1                  // I/O port strobes present
) (
    input  decPkg::opcodeT opcode,                    // Current instruction
    output logic           push,                      // Data stack push
    output logic           pop,                       // Data stack pop
    output logic           memWr,                     // Data memory write
    output logic           indLoad,                   // Indirect load address
    output logic           indStore,                  // Indirect store address
    output logic           bitRev,                    // Bit-reversed indirect address
    output logic           reqIn,                     // Input port request
    output logic           outEn                      // Output port enable
);

    logic pushRaw;                                    // Stack and I/O before group gating
    logic popRaw;
    logic reqInRaw;
    logic outEnRaw;

    // --------------------
    // Opcode decode
    // --------------------

    always_comb begin
        pushRaw  = 1'b0;                              // Everything idle by default
        popRaw   = 1'b0;
        memWr    = 1'b0;
        indLoad  = 1'b0;
        indStore = 1'b0;
        bitRev   = 1'b0;
        reqInRaw = 1'b0;
        outEnRaw = 1'b0;
        case (opcode)
            // Memory group
            decPkg::P_LOD: pushRaw = 1'b1;            // Old acc saved on the stack
            decPkg::LDI:   indLoad = 1'b1;
            decPkg::ILI: begin
                indLoad = 1'b1;
                bitRev  = 1'b1;                       // FFT style addressing
            end
            decPkg::SET:   memWr = 1'b1;
            decPkg::SET_P: begin
                memWr  = 1'b1;
                popRaw = 1'b1;                        // Acc refilled from stack top
            end
            decPkg::STI: begin
                memWr    = 1'b1;
                indStore = 1'b1;
                popRaw   = 1'b1;                      // Address came from the stack
            end
            decPkg::ISI: begin
                memWr    = 1'b1;
                indStore = 1'b1;
                bitRev   = 1'b1;
                popRaw   = 1'b1;
            end
            // Stack group
            decPkg::PSH:   pushRaw = 1'b1;
            decPkg::POP:   popRaw  = 1'b1;
            // I/O group
            decPkg::INN:   reqInRaw = 1'b1;
            decPkg::P_INN: begin
                reqInRaw = 1'b1;
                pushRaw  = 1'b1;
            end
            decPkg::OUT:   outEnRaw = 1'b1;
            // Two-operand ops taking the second operand from the stack
            decPkg::S_ADD,
            decPkg::S_MLT,
            decPkg::S_DIV,
            decPkg::S_MOD,
            decPkg::S_AND,
            decPkg::S_ORR,
            decPkg::S_XOR,
            decPkg::S_LES,
            decPkg::S_GRE,
            decPkg::S_EQU,
            decPkg::S_SHL,
            decPkg::S_SHR,
            decPkg::S_SRS: popRaw = 1'b1;
            // Jumps, memory-form ALU ops, NOP and unknown codes
            default: ;
        endcase
    end

    // --------------------
    // Group enables
    // --------------------

    generate
        if (enableStack) begin : genStack
            assign push = pushRaw;
            assign pop  = popRaw;
        end else begin : genNoStack
            assign push = 1'b0;                       // No stack in this build
            assign pop  = 1'b0;
        end
    endgenerate

    generate
        if (enableIo) begin : genIo
            assign reqIn = reqInRaw;
            assign outEn = outEnRaw;
        end else begin : genNoIo
            assign reqIn = 1'b0;                      // No ports in this build
            assign outEn = 1'b0;
        end
    endgenerate

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module decoderTb -f flist.f -o decoderSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decoderSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0
